/* common/tdoaPkg.sv */
// Types for the TDOA core; all widths follow tdoa_config.svh, lag indices assume NUM_LAGS > 1
package tdoaPkg;

    `include "tdoa_config.svh"

    // One signed microphone sample
    typedef logic signed [`NUM_BITS_SAMPLE-1:0] sample_t;

    // Accumulated correlation value
    typedef logic signed [`NUM_BITS_XCORRS-1:0] xcorr_t;

    typedef logic [$clog2(`NUM_LAGS)-1:0] lagIndex_t;

    // Position of a sample set within its frame
    typedef logic [$clog2(`NUM_SAMPLES)-1:0] frameCount_t;

    // One set of simultaneous samples
    typedef struct packed {
        sample_t                     refSample;
        sample_t [`NUM_XCORRS-1:0]   micSample;
    } sampleSet_t;

    // All lags of one correlator, index 0 is lag 0
    typedef xcorr_t [`NUM_LAGS-1:0] xcorrVector_t;

    typedef xcorrVector_t [`NUM_XCORRS-1:0] xcorrBank_t;

    // One peak result per frame
    typedef struct packed {
        lagIndex_t [`NUM_XCORRS-1:0] lagIndex;
        logic [`NUM_XCORRS-1:0]      found;
    } peakResult_t;

    // Peak search sequencer
    typedef enum logic [1:0] {
        peakIdle,
        peakSearch,
        peakDone
    } peakState_e;

endpackage

/* common/tdoa_config.svh */
// Sizes for the TDOA core; NUM_BITS_XCORRS must cover 2*NUM_BITS_SAMPLE + log2(NUM_SAMPLES)
`ifndef TDOA_CONFIG_SVH
`define TDOA_CONFIG_SVH

// Sample width and frame length
`define NUM_BITS_SAMPLE 12
`define NUM_SAMPLES     64

// Lag range is 0 to 2*MAX_LAGS
`define MAX_LAGS        4
`define NUM_LAGS        (2 * `MAX_LAGS + 1)

`define NUM_XCORRS      3
`define NUM_BITS_XCORRS 30

// Peak threshold and result queue depth, shared with the sink
`define MIN_XCORR_VAL   1
`define RESULT_CREDITS  2

`endif

/* design/frameIngress.sv */
// Grants one frame at a time; sets outside an open frame are ignored, source must send NUM_SAMPLES
`timescale 1ns/10ps
`include "tdoa_config.svh"

module frameIngress import tdoaPkg::*; (
    input  logic        clk50M,
    input  logic        reset,
    input  sampleSet_t  sampleIn,
    input  logic        sampleValid,
    input  logic        slotFree,
    output logic        frameCredit,
    output sampleSet_t  ingressSample,
    output logic        ingressValid,
    output logic        frameStart,
    output logic        frameLast
);

    localparam frameCount_t lastSet = frameCount_t'(`NUM_SAMPLES - 1);

    logic        frameOpen;
    frameCount_t setCount;
    logic        accept;

    assign accept = sampleValid && frameOpen;

    // Credit grant and frame window
    always_ff @(posedge clk50M) begin
        if (reset) begin
            frameOpen   <= 1'b0;
            frameCredit <= 1'b0;
        end else begin
            frameCredit <= 1'b0;
            if (!frameOpen && slotFree) begin
                frameCredit <= 1'b1;
                frameOpen   <= 1'b1;
            end else if (accept && setCount == lastSet) begin
                frameOpen <= 1'b0;
            end
        end
    end

    // Set counter and frame markers
    always_ff @(posedge clk50M) begin
        if (reset) begin
            setCount     <= '0;
            ingressValid <= 1'b0;
            frameStart   <= 1'b0;
            frameLast    <= 1'b0;
        end else begin
            ingressValid <= accept;
            frameStart   <= accept && (setCount == '0);
            frameLast    <= accept && (setCount == lastSet);
            if (accept) begin
                setCount <= (setCount == lastSet) ? '0 : setCount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk50M) begin
        if (accept) begin
            ingressSample <= sampleIn;
        end
    end

endmodule

/* design/resultEgress.sv */
// Result queue with credit-gated output; a slot stays reserved from frameStart until it is sent
`timescale 1ns/10ps
`include "tdoa_config.svh"

module resultEgress import tdoaPkg::*; (
    input  logic         clk50M,
    input  logic         reset,
    input  peakResult_t  peakOut,
    input  logic         peakValid,
    input  logic         frameStart,
    input  logic         resultCreditReturn,
    output peakResult_t  result,
    output logic         resultValid,
    output logic         slotFree
);

    localparam int depth   = `RESULT_CREDITS;
    localparam int ptrBits = (depth > 1) ? $clog2(depth) : 1;
    localparam int cntBits = $clog2(depth + 1);

    typedef logic [ptrBits-1:0] ptr_t;
    typedef logic [cntBits-1:0] count_t;

    peakResult_t queueMem [depth];
    ptr_t   wrPtr;
    ptr_t   rdPtr;
    count_t filled;
    count_t reserved;
    count_t credits;
    logic   pop;
    logic   popFromMem;
    logic   bypass;
    logic   push;

    function automatic ptr_t nextPtr(input ptr_t ptr);
        return (ptr == ptr_t'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Empty queue sends a fresh result straight through
    assign pop        = (credits != '0) && ((filled != '0) || peakValid);
    assign popFromMem = pop && (filled != '0);
    assign bypass     = pop && !popFromMem;
    assign push       = peakValid && !bypass;
    assign slotFree   = (reserved + filled) < count_t'(depth);

    always_ff @(posedge clk50M) begin
        if (reset) begin
            credits     <= count_t'(depth);
            filled      <= '0;
            reserved    <= '0;
            wrPtr       <= '0;
            rdPtr       <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= pop;
            if (pop && !resultCreditReturn) begin
                credits <= credits - 1'b1;
            end else if (!pop && resultCreditReturn && credits != count_t'(depth)) begin
                credits <= credits + 1'b1;
            end
            filled   <= filled + count_t'(push) - count_t'(popFromMem);
            reserved <= reserved + count_t'(frameStart) - count_t'(peakValid);
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (popFromMem) begin
                rdPtr <= nextPtr(rdPtr);
            end
        end
    end

    always_ff @(posedge clk50M) begin
        if (push) begin
            queueMem[wrPtr] <= peakOut;
        end
        if (pop) begin
            result <= popFromMem ? queueMem[rdPtr] : peakOut;
        end
    end

endmodule

/* design/tdoaCore.sv */
// TDOA core top; frame and result flow are credit based, one frame in ingress at a time
`timescale 1ns/10ps

module tdoaCore import tdoaPkg::*; (
    input  logic         clk50M,
    input  logic         reset,
    input  sampleSet_t   sampleIn,
    input  logic         sampleValid,
    output logic         frameCredit,
    output peakResult_t  result,
    output logic         resultValid,
    input  logic         resultCreditReturn
);

    sampleSet_t  ingressSample;
    logic        ingressValid;
    logic        frameStart;
    logic        frameLast;
    logic        slotFree;
    xcorrBank_t  xcorrOut;
    logic        xcorrValid;
    peakResult_t peakOut;
    logic        peakValid;

    frameIngress frameIngress_inst (
        .clk50M        (clk50M),
        .reset         (reset),
        .sampleIn      (sampleIn),
        .sampleValid   (sampleValid),
        .slotFree      (slotFree),
        .frameCredit   (frameCredit),
        .ingressSample (ingressSample),
        .ingressValid  (ingressValid),
        .frameStart    (frameStart),
        .frameLast     (frameLast)
    );

    xcorrLagBank xcorrLagBank_inst (
        .clk50M        (clk50M),
        .reset         (reset),
        .ingressSample (ingressSample),
        .ingressValid  (ingressValid),
        .frameStart    (frameStart),
        .frameLast     (frameLast),
        .xcorrOut      (xcorrOut),
        .xcorrValid    (xcorrValid)
    );

    peak peak_inst (
        .clk50M     (clk50M),
        .reset      (reset),
        .xcorrIn    (xcorrOut),
        .xcorrValid (xcorrValid),
        .peakOut    (peakOut),
        .peakValid  (peakValid)
    );

    // Slot reservation starts with the first set of each frame
    resultEgress resultEgress_inst (
        .clk50M             (clk50M),
        .reset              (reset),
        .peakOut            (peakOut),
        .peakValid          (peakValid),
        .frameStart         (frameStart),
        .resultCreditReturn (resultCreditReturn),
        .result             (result),
        .resultValid        (resultValid),
        .slotFree           (slotFree)
    );

endmodule

/* dv/tdoaCoreTests.svh */
// Directed tests for tdoaCoreTb; included inside the testbench module, needs its signals and tasks
`ifndef TDOA_CORE_TESTS_SVH
`define TDOA_CORE_TESTS_SVH

function automatic int randomSample();
    return int'($urandom_range(4095)) - 2048;
endfunction

task automatic fillRandomRef();
    for (int n = 0; n < `NUM_SAMPLES; n++) begin
        refData[n] = randomSample();
    end
endtask

// Microphone is the reference shifted later by d samples
task automatic delayMic(input int i, input int d);
    for (int n = 0; n < `NUM_SAMPLES; n++) begin
        micData[i][n] = (n >= d) ? refData[n-d] : 0;
    end
endtask

task automatic drainResults();
    while (expectQ.size() != 0) begin
        waitCycle();
    end
    repeat (4) waitCycle();
endtask

task automatic runKnownDelay();
    testName = "knownDelay";
    fillRandomRef();
    delayMic(0, 0);
    delayMic(1, 2);
    delayMic(2, 4);
    sendFrame(1'b0);
    drainResults();
    checkValue(testName, 64'h7, lastResult.found);
endtask

task automatic runThreshold();
    testName = "threshold";
    fillRandomRef();
    delayMic(0, 1);
    delayMic(2, 3);
    for (int n = 0; n < `NUM_SAMPLES; n++) begin
        micData[1][n] = 0;
    end
    sendFrame(1'b0);
    drainResults();
    checkValue(testName, 0, lastResult.found[1]);
    checkValue(testName, 0, lastResult.lagIndex[1]);
endtask

// Equal sums over several lags
task automatic runTies();
    testName = "ties";
    for (int n = 0; n < `NUM_SAMPLES; n++) begin
        refData[n] = 300;
        for (int i = 0; i < `NUM_XCORRS; i++) begin
            micData[i][n] = 300;
        end
    end
    sendFrame(1'b0);
    drainResults();
endtask

task automatic runRandomFrames();
    testName = "randomFrames";
    for (int f = 0; f < 5; f++) begin
        fillRandomRef();
        for (int i = 0; i < `NUM_XCORRS; i++) begin
            for (int n = 0; n < `NUM_SAMPLES; n++) begin
                micData[i][n] = randomSample();
            end
        end
        sendFrame(f % 2 == 1);
    end
    drainResults();
endtask

task automatic runBackPressure();
    int startCount;
    testName = "backPressure";
    startCount = resultCount;
    holdCredits = 1'b1;
    for (int f = 0; f < 4; f++) begin
        fillRandomRef();
        for (int i = 0; i < `NUM_XCORRS; i++) begin
            delayMic(i, (f + i) % 5);
        end
        sendFrame(1'b0);
    end
    repeat (100) waitCycle();
    checkValue(testName, startCount + 2, resultCount);
    checkValue(testName, 0, creditsHeld);
    holdCredits = 1'b0;
    drainResults();
    checkValue(testName, startCount + 4, resultCount);
endtask

task automatic runReset();
    int pulses;
    int results;
    testName = "reset";
    drainResults();
    reset = 1'b1;
    repeat (16) waitCycle();
    pulses = creditPulses;
    results = resultCount;
    reset = 1'b0;
    repeat (20) waitCycle();
    checkValue(testName, pulses + 1, creditPulses);
    checkValue(testName, results, resultCount);
    fillRandomRef();
    delayMic(0, 3);
    delayMic(1, 1);
    delayMic(2, 0);
    sendFrame(1'b0);
    checkValue(testName, results, resultCount);
    drainResults();
    checkValue(testName, results + 1, resultCount);
endtask

`endif

/* dv/tdoaCoreTb.sv */
// TDOA core testbench; inputs change 2 ns after the clock edge, DUT outputs are read at the edge
`timescale 1ns/10ps
`include "tdoa_config.svh"

module tdoaCoreTb import tdoaPkg::*; ();

    localparam int creditWait = 300;
    localparam int numFrames  = 13;
    localparam int cycleLimit = numFrames * (`NUM_SAMPLES + 40) + 1000;

    logic        clk50M = 1'b0;
    logic        reset;
    sampleSet_t  sampleIn;
    logic        sampleValid;
    logic        frameCredit;
    peakResult_t result;
    logic        resultValid;
    logic        resultCreditReturn;

    // Frame under construction, one row per microphone
    int refData [`NUM_SAMPLES];
    int micData [`NUM_XCORRS][`NUM_SAMPLES];

    peakResult_t expectQ [$];
    peakResult_t lastResult;
    string       testName = "startup";
    int          errorCount = 0;
    int          resultCount = 0;
    int          creditPulses = 0;
    int          creditsHeld = 0;
    int          owed = 0;
    int          cycleCount = 0;
    bit          holdCredits = 1'b0;
    bit          giveCredit = 1'b0;

    tdoaCore tdoaCore_inst (
        .clk50M             (clk50M),
        .reset              (reset),
        .sampleIn           (sampleIn),
        .sampleValid        (sampleValid),
        .frameCredit        (frameCredit),
        .result             (result),
        .resultValid        (resultValid),
        .resultCreditReturn (resultCreditReturn)
    );

    always #10 clk50M = ~clk50M;

    task automatic waitCycle();
        @(posedge clk50M);
        #2;
    endtask

    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected=0x%0h actual=0x%0h", name, expected, actual);
            errorCount++;
        end
    endtask

    // Correlation over lags 0..2*MAX_LAGS, then lowest index of the maximum
    function automatic peakResult_t modelPeak();
        peakResult_t res;
        longint acc;
        longint best;
        int bestIdx;
        res = '0;
        for (int i = 0; i < `NUM_XCORRS; i++) begin
            best = 0;
            bestIdx = 0;
            for (int j = 0; j < `NUM_LAGS; j++) begin
                acc = 0;
                for (int n = 0; n < `NUM_SAMPLES; n++) begin
                    if (n >= `MAX_LAGS && n >= j) begin
                        acc += longint'(micData[i][n-`MAX_LAGS]) * longint'(refData[n-j]);
                    end
                end
                if (j == 0 || acc > best) begin
                    best = acc;
                    bestIdx = j;
                end
            end
            if (best >= `MIN_XCORR_VAL) begin
                res.lagIndex[i] = lagIndex_t'(bestIdx);
                res.found[i] = 1'b1;
            end
        end
        return res;
    endfunction

    task automatic takeResult();
        peakResult_t expected;
        if (expectQ.size() == 0) begin
            $display("ERROR: %s got a result while no frame was outstanding", testName);
            errorCount++;
        end else begin
            expected = expectQ.pop_front();
            checkValue(testName, expected, result);
        end
        lastResult = result;
        resultCount++;
        owed++;
    endtask

    // Sink and credit monitor
    always @(posedge clk50M) begin
        if (reset) begin
            creditsHeld = 0;
            owed = 0;
            giveCredit = 1'b0;
        end else begin
            if (frameCredit) begin
                creditPulses++;
                creditsHeld++;
            end
            if (resultValid) begin
                takeResult();
            end
            giveCredit = !holdCredits && owed > 0;
            if (giveCredit) begin
                owed--;
            end
        end
        #2;
        resultCreditReturn = giveCredit;
    end

    // Waits for a credit, then sends the staged frame, optionally with idle gaps
    task automatic sendFrame(input bit withGaps);
        int waited;
        int n;
        waited = 0;
        while (creditsHeld == 0 && waited < creditWait) begin
            waitCycle();
            waited++;
        end
        if (creditsHeld == 0) begin
            $display("ERROR: %s saw no frame credit within %0d cycles", testName, creditWait);
            errorCount++;
        end else begin
            creditsHeld--;
            expectQ.push_back(modelPeak());
            n = 0;
            while (n < `NUM_SAMPLES) begin
                if (withGaps && $urandom_range(3) == 0) begin
                    sampleValid = 1'b0;
                end else begin
                    sampleIn.refSample = sample_t'(refData[n]);
                    for (int i = 0; i < `NUM_XCORRS; i++) begin
                        sampleIn.micSample[i] = sample_t'(micData[i][n]);
                    end
                    sampleValid = 1'b1;
                    n++;
                end
                waitCycle();
            end
            sampleValid = 1'b0;
        end
    endtask

    always @(posedge clk50M) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("ERROR: run did not finish within %0d cycles", cycleLimit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    `include "tdoaCoreTests.svh"

    initial begin
        void'($urandom(32'haa01_ff84));
        reset = 1'b1;
        sampleIn = '0;
        sampleValid = 1'b0;
        resultCreditReturn = 1'b0;
        repeat (16) waitCycle();
        reset = 1'b0;
        runKnownDelay();
        runThreshold();
        runTies();
        runRandomFrames();
        runBackPressure();
        runReset();
        $display("Summary: %0d errors, %0d results, %0d frame credits",
                 errorCount, resultCount, creditPulses);
        if (errorCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* peak/peak.sv */
// Peak search over a captured bank; the lag bank may refill while a search runs
`timescale 1ns/10ps
`include "tdoa_config.svh"

module peak import tdoaPkg::*; (
    input  logic         clk50M,
    input  logic         reset,
    input  xcorrBank_t   xcorrIn,
    input  logic         xcorrValid,
    output peakResult_t  peakOut,
    output logic         peakValid
);

    localparam int numMics = `NUM_XCORRS;

    xcorrBank_t  xcorrHold;
    lagIndex_t   lagIterator;
    logic        searchActive;
    logic        searchFirst;
    lagIndex_t   finderIndex [numMics];
    logic [numMics-1:0] finderFound;

    always_ff @(posedge clk50M) begin
        if (xcorrValid) begin
            xcorrHold <= xcorrIn;
        end
    end

    peakSequencer peakSequencer_inst (
        .clk50M       (clk50M),
        .reset        (reset),
        .xcorrValid   (xcorrValid),
        .lagIterator  (lagIterator),
        .searchActive (searchActive),
        .searchFirst  (searchFirst),
        .peakValid    (peakValid)
    );

    // One finder per correlator, all driven by the same iterator
    for (genvar i = 0; i < numMics; i++) begin : finderGen
        peakFinder peakFinder_inst (
            .clk50M       (clk50M),
            .reset        (reset),
            .xcorrIn      (xcorrHold[i]),
            .lagIterator  (lagIterator),
            .searchActive (searchActive),
            .searchFirst  (searchFirst),
            .lagIndex     (finderIndex[i]),
            .found        (finderFound[i])
        );
    end

    always_comb begin
        peakOut.found = finderFound;
        for (int i = 0; i < numMics; i++) begin
            peakOut.lagIndex[i] = finderIndex[i];
        end
    end

endmodule

/* peak/peakFinder.sv */
// Running maximum over one lag vector; ties keep the lowest lag, outputs valid after the last lag
`timescale 1ns/10ps
`include "tdoa_config.svh"

module peakFinder import tdoaPkg::*; (
    input  logic          clk50M,
    input  logic          reset,
    input  xcorrVector_t  xcorrIn,
    input  lagIndex_t     lagIterator,
    input  logic          searchActive,
    input  logic          searchFirst,
    output lagIndex_t     lagIndex,
    output logic          found
);

    localparam xcorr_t minValue = xcorr_t'(`MIN_XCORR_VAL);

    xcorr_t    current;
    xcorr_t    maxValue;
    lagIndex_t maxIndex;

    assign current = xcorrIn[lagIterator];

    always_ff @(posedge clk50M) begin
        if (reset) begin
            maxValue <= '0;
            maxIndex <= '0;
        end else if (searchActive) begin
            // Strictly greater, so an equal later lag never wins
            if (searchFirst || current > maxValue) begin
                maxValue <= current;
                maxIndex <= lagIterator;
            end
        end
    end

    // Weak maximum reports no peak
    assign found    = (maxValue >= minValue);
    assign lagIndex = found ? maxIndex : '0;

endmodule

/* peak/peakSequencer.sv */
// Steps the lag iterator once per cycle; a new xcorrValid is taken only in idle or done
`timescale 1ns/10ps
`include "tdoa_config.svh"

module peakSequencer import tdoaPkg::*; (
    input  logic       clk50M,
    input  logic       reset,
    input  logic       xcorrValid,
    output lagIndex_t  lagIterator,
    output logic       searchActive,
    output logic       searchFirst,
    output logic       peakValid
);

    localparam lagIndex_t lastLag = lagIndex_t'(`NUM_LAGS - 1);

    peakState_e state;

    always_ff @(posedge clk50M) begin
        if (reset) begin
            state       <= peakIdle;
            lagIterator <= '0;
        end else begin
            case (state)
                peakIdle: begin
                    lagIterator <= '0;
                    if (xcorrValid) begin
                        state <= peakSearch;
                    end
                end
                peakSearch: begin
                    if (lagIterator == lastLag) begin
                        state <= peakDone;
                    end else begin
                        lagIterator <= lagIterator + 1'b1;
                    end
                end
                peakDone: begin
                    // Back-to-back bank may start right away
                    lagIterator <= '0;
                    state       <= xcorrValid ? peakSearch : peakIdle;
                end
                default: begin
                    state <= peakIdle;
                end
            endcase
        end
    end

    assign searchActive = (state == peakSearch);
    assign searchFirst  = searchActive && (lagIterator == '0);
    // Finder outputs are final in the done cycle
    assign peakValid    = (state == peakDone);

endmodule

/* sources.f */
+incdir+common
+incdir+dv
common/tdoaPkg.sv
design/frameIngress.sv
xcorr/xcorrLagBank.sv
peak/peakSequencer.sv
peak/peakFinder.sv
peak/peak.sv
design/resultEgress.sv
design/tdoaCore.sv
dv/tdoaCoreTb.sv

/* xcorr/xcorrLagBank.sv */
// Direct-form lag bank, one multiplier per correlator and lag; expects frameStart on the first set
`timescale 1ns/10ps
`include "tdoa_config.svh"

module xcorrLagBank import tdoaPkg::*; (
    input  logic        clk50M,
    input  logic        reset,
    input  sampleSet_t  ingressSample,
    input  logic        ingressValid,
    input  logic        frameStart,
    input  logic        frameLast,
    output xcorrBank_t  xcorrOut,
    output logic        xcorrValid
);

    localparam int numLags   = `NUM_LAGS;
    localparam int numMics   = `NUM_XCORRS;
    localparam int micDelay  = `MAX_LAGS;
    localparam int prodBits  = 2 * `NUM_BITS_SAMPLE;

    // refLine[0] is the previous reference sample
    sample_t refLine [numLags-1];
    sample_t micLine [numMics][micDelay];

    sample_t refTaps    [numLags];
    sample_t micDelayed [numMics];

    logic signed [prodBits-1:0] product [numMics][numLags];
    logic prodValid;
    logic prodFirst;
    logic prodLast;

    // Tap j is ref[n-j], history before the frame reads as zero
    always_comb begin
        refTaps[0] = ingressSample.refSample;
        for (int k = 1; k < numLags; k++) begin
            refTaps[k] = frameStart ? sample_t'(0) : refLine[k-1];
        end
        for (int i = 0; i < numMics; i++) begin
            micDelayed[i] = frameStart ? sample_t'(0) : micLine[i][micDelay-1];
        end
    end

    // Delay lines and product stage
    always_ff @(posedge clk50M) begin
        if (ingressValid) begin
            refLine[0] <= ingressSample.refSample;
            for (int k = 1; k < numLags - 1; k++) begin
                refLine[k] <= refTaps[k];
            end
            for (int i = 0; i < numMics; i++) begin
                micLine[i][0] <= ingressSample.micSample[i];
                for (int k = 1; k < micDelay; k++) begin
                    micLine[i][k] <= frameStart ? sample_t'(0) : micLine[i][k-1];
                end
                for (int j = 0; j < numLags; j++) begin
                    product[i][j] <= micDelayed[i] * refTaps[j];
                end
            end
        end
    end

    // First product of a frame restarts the sums
    always_ff @(posedge clk50M) begin
        if (prodValid) begin
            for (int i = 0; i < numMics; i++) begin
                for (int j = 0; j < numLags; j++) begin
                    xcorrOut[i][j] <= prodFirst ? xcorr_t'(product[i][j])
                                                : xcorrOut[i][j] + xcorr_t'(product[i][j]);
                end
            end
        end
    end

    always_ff @(posedge clk50M) begin
        if (reset) begin
            prodValid  <= 1'b0;
            prodFirst  <= 1'b0;
            prodLast   <= 1'b0;
            xcorrValid <= 1'b0;
        end else begin
            prodValid  <= ingressValid;
            prodFirst  <= ingressValid && frameStart;
            prodLast   <= ingressValid && frameLast;
            xcorrValid <= prodValid && prodLast;
        end
    end

endmodule
